// ==== hw/ahbPkg.sv ====
package ahbPkg;

    //////////////////////////////////////////////////
    // bus types
    //////////////////////////////////////////////////

    typedef logic [31:0] hdata_t;                       // bus data word
    typedef logic [31:0] haddr_t;                       // bus address

    typedef enum logic [1:0] {
        transIdle   = 2'b00,                            // no transfer
        transBusy   = 2'b01,                            // master stalls a burst
        transNonseq = 2'b10,                            // single or first beat
        transSeq    = 2'b11                             // following beat of a burst
    } htrans_e;

    typedef enum logic [2:0] {
        sizeByte = 3'b000,
        sizeHalf = 3'b001,
        sizeWord = 3'b010                               // widest size on this bus
    } hsize_e;

    typedef enum logic [1:0] {
        slotRam  = 2'd0,
        slotGpio = 2'd1,
        slotDisp = 2'd2,
        slotNone = 2'd3                                 // address outside the map
    } slot_e;

    typedef struct packed {
        haddr_t  haddr;                                 // address phase
        htrans_e htrans;
        logic    hwrite;
        hsize_e  hsize;
        hdata_t  hwdata;                                // valid in data phase only
    } ahbReq_t;                                         // 70 bits, master to all slaves

    typedef struct packed {
        hdata_t hrdata;
        logic   hreadyout;
    } ahbRsp_t;                                         // 33 bits, slave to mux

    //////////////////////////////////////////////////
    // address map, compared against haddr[31:24]
    //////////////////////////////////////////////////

    localparam logic [7:0] ramBase  = 8'h20;
    localparam logic [7:0] gpioBase = 8'h50;
    localparam logic [7:0] dispBase = 8'h53;

    localparam hdata_t badData = 32'hdeadbeef;          // read value for unmapped space

    localparam logic [3:0] gpioOutOffset   = 4'h0;     // output register
    localparam logic [3:0] gpioInOffset    = 4'h4;     // synchronised inputs
    localparam logic [3:0] dispDigitOffset = 4'h0;     // eight hex nibbles
    localparam logic [3:0] dispDotOffset   = 4'h4;     // dot mask

endpackage

// ==== hw/addrDecoder.sv ====
`timescale 1ns/1ps

module addrDecoder (
    input  ahbPkg::haddr_t haddr,                       // address phase address
    output ahbPkg::slot_e  slot                         // slave slot for this address
);

    // top byte picks the slave, the rest is the slave's own offset
    logic [7:0] region;

    assign region = haddr[31:24];

    always_comb begin
        case (region)
            ahbPkg::ramBase:  slot = ahbPkg::slotRam;
            ahbPkg::gpioBase: slot = ahbPkg::slotGpio;
            ahbPkg::dispBase: slot = ahbPkg::slotDisp;
            default:          slot = ahbPkg::slotNone;  // unmapped, mux answers badData
        endcase
    end

endmodule

// ==== hw/respMux.sv ====
`timescale 1ns/1ps

module respMux (
    input  logic            HCLK,
    input  logic            reset,
    input  ahbPkg::slot_e   slot,                       // from decoder, address phase
    input  ahbPkg::htrans_e trans,                      // transfer type of address phase
    input  ahbPkg::ahbRsp_t ramRsp,
    input  ahbPkg::ahbRsp_t gpioRsp,
    input  ahbPkg::ahbRsp_t dispRsp,
    output ahbPkg::hdata_t  hrdata,                     // to master
    output logic            hready                      // to master and all slaves
);

    ahbPkg::slot_e dataSlot;                            // slave owning the data phase
    logic          active;

    assign active = (trans == ahbPkg::transNonseq) || (trans == ahbPkg::transSeq);

    always_ff @(posedge HCLK) begin
        if (reset) begin
            dataSlot <= ahbPkg::slotNone;
        end else if (hready) begin                      // address phase only when ready
            dataSlot <= active ? slot : ahbPkg::slotNone;
        end
    end

    always_comb begin
        case (dataSlot)
            ahbPkg::slotRam:  {hrdata, hready} = ramRsp;
            ahbPkg::slotGpio: {hrdata, hready} = gpioRsp;
            ahbPkg::slotDisp: {hrdata, hready} = dispRsp;
            default:          {hrdata, hready} = {ahbPkg::badData, 1'b1};  // zero wait
        endcase
    end

    // a stuck or floating slave ready would hang the whole bus
    hreadyKnown: assert property (@(posedge HCLK) disable iff (reset) !$isunknown(hready));

endmodule

// ==== hw/ahbRam.sv ====
`timescale 1ns/1ps

module ahbRam #(
    parameter int ramWords = 1024                       // depth in words, power of two
) (
    input  logic            HCLK,
    input  logic            reset,
    input  logic            sel,                        // from decoder
    input  logic            hready,                     // previous transfer completing
    input  ahbPkg::ahbReq_t req,
    output ahbPkg::ahbRsp_t rsp
);

    localparam int addrBits = $clog2(ramWords);

    ahbPkg::hdata_t        mem [ramWords];              // word organised storage
    logic                  addrPhase;
    logic                  phaseValid;                  // a transfer is in its data phase
    logic                  phaseWrite;
    ahbPkg::hsize_e        phaseSize;
    logic [addrBits+1:0]   phaseAddr;                   // byte address within the RAM
    logic [addrBits-1:0]   wordIdx;
    logic [3:0]            laneEn;                      // one bit per byte lane

    assign addrPhase = sel && hready &&
                       (req.htrans inside {ahbPkg::transNonseq, ahbPkg::transSeq});
    assign wordIdx   = phaseAddr[addrBits+1:2];

    //////////////////////////////////////////////////
    // address phase capture
    //////////////////////////////////////////////////

    always_ff @(posedge HCLK) begin
        if (reset) begin
            phaseValid <= 1'b0;
            phaseWrite <= 1'b0;
        end else if (hready) begin
            phaseValid <= addrPhase;
            phaseWrite <= addrPhase && req.hwrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (addrPhase) begin
            phaseSize <= req.hsize;
            phaseAddr <= req.haddr[addrBits+1:0];
        end
    end

    //////////////////////////////////////////////////
    // data phase
    //////////////////////////////////////////////////

    always_comb begin
        case (phaseSize)
            ahbPkg::sizeByte: laneEn = 4'b0001 << phaseAddr[1:0];
            ahbPkg::sizeHalf: laneEn = phaseAddr[1] ? 4'b1100 : 4'b0011;
            default:          laneEn = 4'b1111;         // whole word
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (phaseValid && phaseWrite && hready) begin   // edge ending the write data phase
            for (int i = 0; i < 4; i++) begin
                if (laneEn[i]) mem[wordIdx][8*i +: 8] <= req.hwdata[8*i +: 8];
            end
        end
    end

    assign rsp = '{hrdata: mem[wordIdx], hreadyout: 1'b1};  // read from captured address

    transferSize: assert property (@(posedge HCLK) disable iff (reset)
        addrPhase |-> (req.hsize <= ahbPkg::sizeWord));

endmodule

// ==== hw/ahbGpio.sv ====
`timescale 1ns/1ps

module ahbGpio (
    input  logic            HCLK,
    input  logic            reset,
    input  logic            sel,
    input  logic            hready,
    input  ahbPkg::ahbReq_t req,
    output ahbPkg::ahbRsp_t rsp,
    input  logic [15:0]     gpioIn,                     // asynchronous pins
    output logic [15:0]     gpioOut
);

    logic        addrPhase;
    logic        phaseValid;
    logic        phaseWrite;
    logic [3:0]  phaseOff;                              // register offset of data phase
    logic [15:0] syncA;                                 // first stage, may be metastable
    logic [15:0] syncB;                                 // second stage, safe to read
    logic [15:0] readVal;

    assign addrPhase = sel && hready &&
                       (req.htrans inside {ahbPkg::transNonseq, ahbPkg::transSeq});

    always_ff @(posedge HCLK) begin
        if (reset) begin
            phaseValid <= 1'b0;
            phaseWrite <= 1'b0;
        end else if (hready) begin
            phaseValid <= addrPhase;
            phaseWrite <= addrPhase && req.hwrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (addrPhase) phaseOff <= req.haddr[3:0];
    end

    //////////////////////////////////////////////////
    // output register and input synchroniser
    //////////////////////////////////////////////////

    always_ff @(posedge HCLK) begin
        if (reset) begin
            gpioOut <= '0;
        end else if (phaseValid && phaseWrite && hready &&
                     phaseOff == ahbPkg::gpioOutOffset) begin
            gpioOut <= req.hwdata[15:0];                // input offset writes fall through
        end
    end

    always_ff @(posedge HCLK) begin
        syncA <= gpioIn;
        syncB <= syncA;
    end

    always_comb begin
        case (phaseOff)
            ahbPkg::gpioOutOffset: readVal = gpioOut;
            ahbPkg::gpioInOffset:  readVal = syncB;
            default:               readVal = '0;
        endcase
    end

    assign rsp = '{hrdata: {16'b0, readVal}, hreadyout: 1'b1};

endmodule

// ==== hw/segDisplay.sv ====
`timescale 1ns/1ps

module segDisplay #(
    parameter int scanDiv = 50000                       // clock cycles per digit
) (
    input  logic            HCLK,
    input  logic            reset,
    input  logic            sel,
    input  logic            hready,
    input  ahbPkg::ahbReq_t req,
    output ahbPkg::ahbRsp_t rsp,
    output logic [7:0]      digit,                      // active low, digit 0 on right
    output logic [7:0]      segment                     // active low, P A B C D E F G
);

    localparam int cntBits = (scanDiv > 1) ? $clog2(scanDiv) : 1;

    logic               addrPhase;
    logic               phaseValid;
    logic               phaseWrite;
    logic [3:0]         phaseOff;
    ahbPkg::hdata_t     digitReg;                       // nibble i drives digit i
    logic [7:0]         dotReg;
    logic               shown;                          // blank until first write
    logic [cntBits-1:0] divCnt;
    logic [2:0]         digitIdx;                       // wraps 7 to 0 by itself
    logic [3:0]         nibble;
    logic [6:0]         glyph;                          // A..G, active high

    assign addrPhase = sel && hready &&
                       (req.htrans inside {ahbPkg::transNonseq, ahbPkg::transSeq});

    always_ff @(posedge HCLK) begin
        if (reset) begin
            phaseValid <= 1'b0;
            phaseWrite <= 1'b0;
        end else if (hready) begin
            phaseValid <= addrPhase;
            phaseWrite <= addrPhase && req.hwrite;
        end
        if (addrPhase) phaseOff <= req.haddr[3:0];
    end

    always_ff @(posedge HCLK) begin
        if (reset) begin
            digitReg <= '0;
            dotReg   <= '0;
            shown    <= 1'b0;
        end else if (phaseValid && phaseWrite && hready) begin
            if (phaseOff == ahbPkg::dispDigitOffset) digitReg <= req.hwdata;
            if (phaseOff == ahbPkg::dispDotOffset)   dotReg   <= req.hwdata[7:0];
            shown <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // scan and decode
    //////////////////////////////////////////////////

    always_ff @(posedge HCLK) begin
        if (reset) begin
            divCnt   <= '0;
            digitIdx <= '0;
        end else if (divCnt == cntBits'(scanDiv - 1)) begin
            divCnt   <= '0;
            digitIdx <= digitIdx + 3'd1;                // next digit
        end else begin
            divCnt   <= divCnt + 1'b1;
        end
    end

    assign nibble = digitReg[4*digitIdx +: 4];

    always_comb begin
        case (nibble)
            4'h0: glyph = 7'h7e;
            4'h1: glyph = 7'h30;
            4'h2: glyph = 7'h6d;
            4'h3: glyph = 7'h79;
            4'h4: glyph = 7'h33;
            4'h5: glyph = 7'h5b;
            4'h6: glyph = 7'h5f;
            4'h7: glyph = 7'h70;
            4'h8: glyph = 7'h7f;
            4'h9: glyph = 7'h7b;
            4'ha: glyph = 7'h77;
            4'hb: glyph = 7'h1f;                        // lower case b
            4'hc: glyph = 7'h4e;
            4'hd: glyph = 7'h3d;                        // lower case d
            4'he: glyph = 7'h4f;
            default: glyph = 7'h47;                     // F
        endcase
    end

    assign digit   = shown ? ~(8'b1 << digitIdx) : 8'hff;
    assign segment = shown ? ~{dotReg[digitIdx], glyph} : 8'hff;

    assign rsp = '{hrdata: (phaseOff == ahbPkg::dispDigitOffset) ? digitReg :
                           (phaseOff == ahbPkg::dispDotOffset) ? {24'b0, dotReg} : '0,
                   hreadyout: 1'b1};

    // lit digit steps only on a divider wrap and leaves one line low
    oneDigit: assert property (@(posedge HCLK) disable iff (reset)
        $past(shown) && !$stable(digit) |-> $onehot(~digit) &&
        $past(divCnt) == cntBits'(scanDiv - 1));

endmodule

// ==== hw/ahbSystem.sv ====
`timescale 1ns/1ps

module ahbSystem #(
    parameter int ramWords = 1024,
    parameter int scanDiv  = 50000
) (
    input  logic            HCLK,
    input  logic            reset,                      // synchronous, active high
    input  ahbPkg::ahbReq_t req,                        // from the single bus master
    output ahbPkg::hdata_t  hrdata,
    output logic            hready,
    input  logic [15:0]     gpioIn,
    output logic [15:0]     gpioOut,
    output logic [7:0]      digit,
    output logic [7:0]      segment
);

    ahbPkg::slot_e   slot;                              // address phase slave choice
    ahbPkg::ahbRsp_t ramRsp;
    ahbPkg::ahbRsp_t gpioRsp;
    ahbPkg::ahbRsp_t dispRsp;
    logic            ramSel;
    logic            gpioSel;
    logic            dispSel;

    //////////////////////////////////////////////////
    // fabric
    //////////////////////////////////////////////////

    addrDecoder decoder (.haddr(req.haddr), .slot(slot));

    assign ramSel  = (slot == ahbPkg::slotRam);
    assign gpioSel = (slot == ahbPkg::slotGpio);
    assign dispSel = (slot == ahbPkg::slotDisp);

    respMux mux (
        .HCLK(HCLK), .reset(reset), .slot(slot), .trans(req.htrans),
        .ramRsp(ramRsp), .gpioRsp(gpioRsp), .dispRsp(dispRsp),
        .hrdata(hrdata), .hready(hready)                // hready also fed back to slaves
    );

    //////////////////////////////////////////////////
    // slaves
    //////////////////////////////////////////////////

    ahbRam #(.ramWords(ramWords)) ram (
        .HCLK(HCLK), .reset(reset), .sel(ramSel), .hready(hready), .req(req), .rsp(ramRsp)
    );

    ahbGpio gpio (
        .HCLK(HCLK), .reset(reset), .sel(gpioSel), .hready(hready), .req(req), .rsp(gpioRsp),
        .gpioIn(gpioIn), .gpioOut(gpioOut)
    );

    segDisplay #(.scanDiv(scanDiv)) disp (
        .HCLK(HCLK), .reset(reset), .sel(dispSel), .hready(hready), .req(req), .rsp(dispRsp),
        .digit(digit), .segment(segment)
    );

endmodule

// ==== dv/busTasks.svh ====
//////////////////////////////////////////////////
// bus driver
//////////////////////////////////////////////////

typedef struct packed {
    ahbPkg::haddr_t addr;
    logic           write;
    ahbPkg::hsize_e size;
    ahbPkg::hdata_t data;                               // ignored for reads
} xfer_t;

localparam int readyTimeout = 20;                       // cycles hready may stay low

xfer_t          pending[$];                             // queued beats for runTransfers
ahbPkg::hdata_t readBack[$];                            // data phase value of every beat

function automatic ahbPkg::haddr_t regAddr(logic [7:0] base, logic [23:0] offset);
    return {base, offset};
endfunction

// hold the current drive until hready is high, sampled at the falling edge
task automatic waitReady();
    int spins;
    spins = 0;
    while (hready !== 1'b1 && spins < readyTimeout) begin
        @(negedge HCLK);
        spins++;
    end
    if (hready !== 1'b1) begin
        errors++;
        $display("hready stayed low for %0d cycles at %0t", spins, $time);
        finishRun();
    end
endtask

task automatic queueWrite(ahbPkg::haddr_t addr, ahbPkg::hsize_e size, ahbPkg::hdata_t data);
    pending.push_back('{addr, 1'b1, size, data});
endtask

task automatic queueRead(ahbPkg::haddr_t addr);
    pending.push_back('{addr, 1'b0, ahbPkg::sizeWord, '0});
endtask

// issues every queued beat back to back, address phase overlapping previous data phase
task automatic runTransfers();
    xfer_t cur;
    xfer_t prev;
    logic  prevValid;
    logic  issued;
    readBack.delete();
    prevValid = 1'b0;
    while (pending.size() > 0 || prevValid) begin
        @(negedge HCLK);
        if (prevValid) req.hwdata = prev.data;          // data phase of the previous beat
        issued = (pending.size() > 0);
        if (issued) begin
            cur        = pending.pop_front();
            req.haddr  = cur.addr;
            req.htrans = ahbPkg::transNonseq;
            req.hwrite = cur.write;
            req.hsize  = cur.size;
        end else begin
            req.htrans = ahbPkg::transIdle;
        end
        waitReady();
        if (prevValid) readBack.push_back(hrdata);      // stable, slave already registered
        prevValid = issued;
        prev      = cur;
    end
    @(negedge HCLK);                                    // edge ending the last data phase
endtask

task automatic ahbWrite(ahbPkg::haddr_t addr, ahbPkg::hdata_t data, ahbPkg::hsize_e size);
    queueWrite(addr, size, data);
    runTransfers();
endtask

task automatic ahbRead(ahbPkg::haddr_t addr, output ahbPkg::hdata_t data);
    queueRead(addr);
    runTransfers();
    data = readBack[0];
endtask

//////////////////////////////////////////////////
// compare tasks and reference models
//////////////////////////////////////////////////

task automatic checkWord(string name, ahbPkg::hdata_t expected, ahbPkg::hdata_t actual);
    if (actual !== expected) begin
        errors++;
        $display("FAIL %s: expected %h, got %h at %0t", name, expected, actual, $time);
    end
endtask

task automatic checkPins(string name, logic [15:0] expected, logic [15:0] actual);
    if (actual !== expected) begin
        errors++;
        $display("FAIL %s: expected %h, got %h at %0t", name, expected, actual, $time);
    end
endtask

task automatic checkSegment(string name, logic [7:0] expected, logic [7:0] actual);
    if (actual !== expected) begin
        errors++;
        $display("FAIL %s: expected %h, got %h at %0t", name, expected, actual, $time);
    end
endtask

// little endian lanes, only the bytes covered by size and address change
function automatic ahbPkg::hdata_t mergeLanes(ahbPkg::hdata_t old, ahbPkg::haddr_t addr,
                                              ahbPkg::hsize_e size, ahbPkg::hdata_t wdata);
    ahbPkg::hdata_t mask;
    case (size)
        ahbPkg::sizeByte: mask = 32'h0000_00ff << (8 * addr[1:0]);
        ahbPkg::sizeHalf: mask = 32'h0000_ffff << (16 * addr[1]);
        default:          mask = 32'hffff_ffff;
    endcase
    return (old & ~mask) | (wdata & mask);
endfunction

// active low pattern P A B C D E F G for one hex digit
function automatic logic [7:0] segmentGlyph(logic [3:0] value, logic dot);
    logic [6:0] lit;                                    // segments a..g, 1 = lit
    case (value)
        4'h0: lit = 7'b1111110;
        4'h1: lit = 7'b0110000;
        4'h2: lit = 7'b1101101;
        4'h3: lit = 7'b1111001;
        4'h4: lit = 7'b0110011;
        4'h5: lit = 7'b1011011;
        4'h6: lit = 7'b1011111;
        4'h7: lit = 7'b1110000;
        4'h8: lit = 7'b1111111;
        4'h9: lit = 7'b1111011;
        4'ha: lit = 7'b1110111;
        4'hb: lit = 7'b0011111;                         // b
        4'hc: lit = 7'b1001110;
        4'hd: lit = 7'b0111101;                         // d
        4'he: lit = 7'b1001111;
        default: lit = 7'b1000111;
    endcase
    return ~{dot, lit};
endfunction

// ==== dv/busSystemTb.sv ====
`timescale 1ns/1ps

module busSystemTb;

    localparam int scanDiv     = 4;                     // short scan period
    localparam int scanTimeout = 80;                    // cycles to wait for one digit

    logic            HCLK;
    logic            reset;
    ahbPkg::ahbReq_t req;
    ahbPkg::hdata_t  hrdata;
    logic            hready;
    logic [15:0]     gpioIn;
    logic [15:0]     gpioOut;
    logic [7:0]      digit;
    logic [7:0]      segment;
    int              errors;
    ahbPkg::hdata_t  ramShadow;                         // expected RAM word 0
    logic [15:0]     pinsShadow;                        // expected gpioOut

    `include "busTasks.svh"

    ahbSystem #(.ramWords(1024), .scanDiv(scanDiv)) dut_i (
        .HCLK(HCLK), .reset(reset), .req(req), .hrdata(hrdata), .hready(hready),
        .gpioIn(gpioIn), .gpioOut(gpioOut), .digit(digit), .segment(segment)
    );

    always #5 HCLK = ~HCLK;

    task automatic finishRun();
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic testRamWords();
        ahbPkg::haddr_t addrs[16];
        ahbPkg::hdata_t words[16];
        for (int i = 0; i < 16; i++) begin
            addrs[i] = regAddr(ahbPkg::ramBase, 24'((i * 64 + $urandom_range(63)) * 4));
            words[i] = $urandom;                        // one word per 64-word band, no repeats
            queueWrite(addrs[i], ahbPkg::sizeWord, words[i]);
        end
        runTransfers();
        for (int i = 0; i < 16; i++) queueRead(addrs[i]);
        runTransfers();                                 // reads overlap in the pipeline
        for (int i = 0; i < 16; i++) checkWord("hrdata", words[i], readBack[i]);
    endtask

    task automatic testRamLanes();
        ahbPkg::haddr_t base;
        ahbPkg::hdata_t wdata;
        base      = regAddr(ahbPkg::ramBase, 24'h0);
        ramShadow = $urandom;
        queueWrite(base, ahbPkg::sizeWord, ramShadow);
        wdata     = $urandom;
        queueWrite(base + 1, ahbPkg::sizeByte, wdata);
        ramShadow = mergeLanes(ramShadow, base + 1, ahbPkg::sizeByte, wdata);
        wdata     = $urandom;
        queueWrite(base + 2, ahbPkg::sizeHalf, wdata);
        ramShadow = mergeLanes(ramShadow, base + 2, ahbPkg::sizeHalf, wdata);
        wdata     = $urandom;
        queueWrite(base + 3, ahbPkg::sizeByte, wdata);
        ramShadow = mergeLanes(ramShadow, base + 3, ahbPkg::sizeByte, wdata);
        queueRead(base);                                // directly behind the last write
        runTransfers();
        checkWord("hrdata", ramShadow, readBack[4]);
    endtask

    task automatic testGpio();
        ahbPkg::hdata_t rd;
        logic [15:0]    pins;
        pinsShadow = 16'($urandom);
        ahbWrite(regAddr(ahbPkg::gpioBase, ahbPkg::gpioOutOffset),
                 {16'($urandom), pinsShadow}, ahbPkg::sizeWord);   // upper half unused
        checkPins("gpioOut", pinsShadow, gpioOut);
        ahbRead(regAddr(ahbPkg::gpioBase, ahbPkg::gpioOutOffset), rd);
        checkWord("hrdata", {16'b0, pinsShadow}, rd);
        pins = 16'($urandom);
        @(negedge HCLK);
        gpioIn = pins;                                  // read data lands two cycles later
        ahbRead(regAddr(ahbPkg::gpioBase, ahbPkg::gpioInOffset), rd);
        checkWord("hrdata", {16'b0, pins}, rd);
    endtask

    task automatic testUnmapped();
        ahbPkg::hdata_t rd;
        ahbRead(regAddr(8'h40, 24'h10), rd);
        checkWord("hrdata", ahbPkg::badData, rd);
        ahbWrite(regAddr(8'h40, 24'h0), $urandom, ahbPkg::sizeWord);  // offset 0 in every slave
        ahbRead(regAddr(ahbPkg::ramBase, 24'h0), rd);
        checkWord("hrdata", ramShadow, rd);
        checkPins("gpioOut", pinsShadow, gpioOut);
        ahbRead(regAddr(ahbPkg::dispBase, ahbPkg::dispDigitOffset), rd);
        checkWord("hrdata", 32'h0, rd);
        checkSegment("digit", 8'hff, digit);            // display never written, still dark
    endtask

    task automatic testDisplay();
        ahbPkg::hdata_t digits;
        logic [7:0]     dots;
        int             spins;
        digits = $urandom;
        dots   = 8'($urandom);
        queueWrite(regAddr(ahbPkg::dispBase, ahbPkg::dispDigitOffset), ahbPkg::sizeWord, digits);
        queueWrite(regAddr(ahbPkg::dispBase, ahbPkg::dispDotOffset), ahbPkg::sizeWord,
                   {24'($urandom), dots});
        queueRead(regAddr(ahbPkg::dispBase, ahbPkg::dispDigitOffset));
        queueRead(regAddr(ahbPkg::dispBase, ahbPkg::dispDotOffset));
        runTransfers();
        checkWord("hrdata", digits, readBack[2]);
        checkWord("hrdata", {24'b0, dots}, readBack[3]);
        for (int i = 0; i < 8; i++) begin
            spins = 0;
            while (digit !== ~(8'b1 << i) && spins < scanTimeout) begin
                @(negedge HCLK);
                spins++;
            end
            if (digit !== ~(8'b1 << i)) begin
                errors++;
                $display("digit %0d never became active within %0d cycles", i, scanTimeout);
            end else begin
                checkSegment("segment", segmentGlyph(digits[4*i +: 4], dots[i]), segment);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////

    initial begin
        int seed;
        HCLK   = 1'b0;
        reset  = 1'b1;
        gpioIn = '0;
        req    = '{haddr: '0, htrans: ahbPkg::transIdle, hwrite: 1'b0,
                   hsize: ahbPkg::sizeWord, hwdata: '0};
        errors = 0;
        seed   = $urandom(92197);
        repeat (8) @(negedge HCLK);
        reset = 1'b0;
        checkSegment("segment", 8'hff, segment);        // blank out of reset
        testRamWords();
        testRamLanes();
        testGpio();
        testUnmapped();
        testDisplay();
        finishRun();
    end

endmodule

// ==== flist.f ====
+incdir+dv
hw/ahbPkg.sv
hw/addrDecoder.sv
hw/respMux.sv
hw/ahbRam.sv
hw/ahbGpio.sv
hw/segDisplay.sv
hw/ahbSystem.sv
dv/busSystemTb.sv

// ==== Bender.yml ====
package:
  name: ahb_system

sources:
  - hw/ahbPkg.sv
  - hw/addrDecoder.sv
  - hw/respMux.sv
  - hw/ahbRam.sv
  - hw/ahbGpio.sv
  - hw/segDisplay.sv
  - hw/ahbSystem.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/busSystemTb.sv
